// File: Makefile
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_sad_top: $(SRCS) verilog.f
	verilator --binary --timing --assert -j 0 --top-module tb_sad_top -f verilog.f

run: obj_dir/Vtb_sad_top
	./obj_dir/Vtb_sad_top | tee sim.log
	@if grep -q "Test completed successfully" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: sad_apb_regs.sv
`timescale 1ns/1ps

module sad_apb_regs (
    input  logic                                   adc_sampleclk,
    input  logic                                   reset,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [sad_regs_pkg::SAD_ADDR_BITS-1:0] paddr,
    input  logic [sad_regs_pkg::SAD_DATA_BITS-1:0] pwdata,
    output logic [sad_regs_pkg::SAD_DATA_BITS-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    input  logic                                   trigger,
    input  logic                                   running,
    output sad_cfg_pkg::ref_array_t                ref_samples,
    output sad_cfg_pkg::sum_t                      threshold,
    output sad_cfg_pkg::sample_t                   max_dev
);
    import sad_cfg_pkg::*;
    import sad_regs_pkg::*;

    logic                     access;
    logic                     wr_en;
    logic [SAD_ADDR_BITS-1:0] ref_offset;
    logic [SAD_ADDR_BITS-3:0] ref_word;
    ref_idx_t                 ref_idx;
    logic                     sel_ref;
    logic                     sel_thr;
    logic                     sel_dev;
    logic                     sel_status;
    logic                     mapped;
    logic                     triggered;
    logic [SAD_DATA_BITS-1:0] rdata;

    assign pready = 1'b1;              // zero wait states
    assign access = psel & penable;    // access phase
    assign wr_en  = access & pwrite;

    // reference window decode, word aligned only
    assign ref_offset = paddr - SAD_REF_BASE;
    assign ref_word   = ref_offset[SAD_ADDR_BITS-1:2];
    assign ref_idx    = ref_idx_t'(ref_word);
    assign sel_ref    = (ref_offset[1:0] == 2'b00) && (ref_word < SAD_REF_SAMPLES);

    assign sel_thr    = (paddr == SAD_THRESHOLD_ADDR);
    assign sel_dev    = (paddr == SAD_MAX_DEV_ADDR);
    assign sel_status = (paddr == SAD_STATUS_ADDR);
    assign mapped     = sel_ref | sel_thr | sel_dev | sel_status;

    assign pslverr = access & ~mapped;

    // configuration registers
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_samples <= '0;
            threshold   <= '0;
            max_dev     <= '0;
        end else if (wr_en) begin
            if (sel_ref) begin
                ref_samples[ref_idx] <= pwdata[SAD_SAMPLE_BITS-1:0];
            end
            if (sel_thr) begin
                threshold <= pwdata[SAD_SUM_BITS-1:0];
            end
            if (sel_dev) begin
                max_dev <= pwdata[SAD_SAMPLE_BITS-1:0];
            end
        end
    end

    // sticky trigger flag, a trigger beats a clear on the same edge
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            triggered <= 1'b0;
        end else if (trigger) begin
            triggered <= 1'b1;
        end else if (wr_en && sel_status) begin
            triggered <= 1'b0;
        end
    end

    always_comb begin
        rdata = '0;
        if (sel_ref) begin
            rdata = SAD_DATA_BITS'(ref_samples[ref_idx]);
        end else if (sel_thr) begin
            rdata = SAD_DATA_BITS'(threshold);
        end else if (sel_dev) begin
            rdata = SAD_DATA_BITS'(max_dev);
        end else if (sel_status) begin
            rdata[SAD_STATUS_TRIGGERED] = triggered;
            rdata[SAD_STATUS_RUNNING]   = running;
        end
    end

    assign prdata = (psel && !pwrite) ? rdata : '0;  // unmapped reads give zero

endmodule

// File: sad_cfg_pkg.sv
package sad_cfg_pkg;

    // sample and window sizes
    localparam int SAD_SAMPLE_BITS = 12;
    localparam int SAD_REF_SAMPLES = 8;

    // worst case is SAD_REF_SAMPLES * (2**SAD_SAMPLE_BITS - 1), fits with margin
    localparam int SAD_SUM_BITS    = 16;

    localparam int SAD_IDX_BITS    = $clog2(SAD_REF_SAMPLES);

    // one adc sample, or the absolute difference of two
    typedef logic [SAD_SAMPLE_BITS-1:0] sample_t;

    // window sum, also used for the threshold
    typedef logic [SAD_SUM_BITS-1:0] sum_t;

    // position inside the reference
    typedef logic [SAD_IDX_BITS-1:0] ref_idx_t;

    // whole reference pattern, entry n is sample n of the window
    typedef logic [SAD_REF_SAMPLES-1:0][SAD_SAMPLE_BITS-1:0] ref_array_t;

    // one bit per lane
    typedef logic [SAD_REF_SAMPLES-1:0] lane_vec_t;

endpackage

// File: sad_lane.sv
`timescale 1ns/1ps

module sad_lane (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  logic                    lanes_clear,
    input  logic                    start,
    input  sad_cfg_pkg::sample_t    adc_data,
    input  sad_cfg_pkg::ref_array_t ref_samples,
    input  sad_cfg_pkg::sum_t       threshold,
    input  sad_cfg_pkg::sample_t    max_dev,
    output logic                    hit
);
    import sad_cfg_pkg::*;

    logic     active;
    ref_idx_t pos;
    logic     take;
    sample_t  ref_val;
    sample_t  abs_diff;
    logic     diff_valid;
    sample_t  diff;
    logic     diff_over;
    logic     diff_last;
    sum_t     sum;
    logic     spoiled;
    logic     window_done;

    // pos is still 0 from the idle clear when start arrives
    assign take     = start | active;
    assign ref_val  = ref_samples[pos];
    assign abs_diff = (adc_data > ref_val) ? adc_data - ref_val : ref_val - adc_data;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || lanes_clear) begin
            active <= 1'b0;
            pos    <= '0;
        end else if (take) begin
            active <= 1'b1;
            pos    <= (pos == ref_idx_t'(SAD_REF_SAMPLES - 1)) ? '0 : pos + 1'b1;
        end
    end

    // difference stage, sample k lands here at edge k
    always_ff @(posedge adc_sampleclk) begin
        if (reset || lanes_clear) begin
            diff_valid <= 1'b0;
        end else begin
            diff_valid <= take;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        diff      <= abs_diff;
        diff_over <= (max_dev != '0) && (abs_diff > max_dev);
        diff_last <= (pos == ref_idx_t'(SAD_REF_SAMPLES - 1));
    end

    // accumulate at edge k+1, judge the finished window at edge k+2
    always_ff @(posedge adc_sampleclk) begin
        if (reset || lanes_clear) begin
            sum         <= '0;
            spoiled     <= 1'b0;
            window_done <= 1'b0;
            hit         <= 1'b0;
        end else begin
            hit         <= window_done && (sum <= threshold) && !spoiled;
            window_done <= diff_valid & diff_last;
            if (diff_valid) begin
                if (window_done) begin    // new window opens with this diff
                    sum     <= sum_t'(diff);
                    spoiled <= diff_over;
                end else begin
                    sum     <= sum + sum_t'(diff);
                    spoiled <= spoiled | diff_over;
                end
            end
        end
    end

endmodule

// File: sad_regs_pkg.sv
package sad_regs_pkg;

    // apb bus widths
    localparam int SAD_ADDR_BITS = 8;
    localparam int SAD_DATA_BITS = 32;

    // reference word n at SAD_REF_BASE + 4*n, low sample bits used
    localparam logic [SAD_ADDR_BITS-1:0] SAD_REF_BASE       = 8'h00;

    localparam logic [SAD_ADDR_BITS-1:0] SAD_THRESHOLD_ADDR = 8'h80;  // low 16 bits
    localparam logic [SAD_ADDR_BITS-1:0] SAD_MAX_DEV_ADDR   = 8'h84;  // low 12 bits, 0 = off
    localparam logic [SAD_ADDR_BITS-1:0] SAD_STATUS_ADDR    = 8'h88;  // any write clears triggered

    // status bit positions
    localparam int SAD_STATUS_TRIGGERED = 0;  // sticky
    localparam int SAD_STATUS_RUNNING   = 1;  // read only

endpackage

// File: sad_sequencer.sv
`timescale 1ns/1ps

module sad_sequencer (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic                   arm,
    input  logic                   active,
    input  sad_cfg_pkg::lane_vec_t hits,
    output sad_cfg_pkg::lane_vec_t lane_start,
    output logic                   lanes_clear,
    output logic                   running,
    output logic                   trigger
);
    import sad_cfg_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_RUNNING
    } state_t;

    state_t   state;
    ref_idx_t start_cnt;     // lane to start next
    logic     starts_done;   // all lanes started this run
    logic     go;
    logic     any_hit;

    assign go      = arm & active;
    assign any_hit = |hits;

    assign running     = (state == ST_RUNNING);
    assign lanes_clear = (state == ST_IDLE);   // holds every lane in clear while idle

    // one lane per cycle, lane i just before sample i
    assign lane_start = (running && !starts_done) ? lane_vec_t'(1) << start_cnt : '0;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state   <= ST_IDLE;
            trigger <= 1'b0;
        end else begin
            trigger <= running & any_hit;  // single cycle, state leaves running
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_RUNNING;
                    end
                end
                ST_RUNNING: begin
                    if (!go || any_hit) begin
                        state <= ST_IDLE;  // lanes get cleared next cycle
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // start counter, restarts with every run
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !running) begin
            start_cnt   <= '0;
            starts_done <= 1'b0;
        end else if (!starts_done) begin
            if (start_cnt == ref_idx_t'(SAD_REF_SAMPLES - 1)) begin
                starts_done <= 1'b1;
            end else begin
                start_cnt <= start_cnt + 1'b1;
            end
        end
    end

endmodule

// File: sad_top.sv
`timescale 1ns/1ps

module sad_top (
    input  logic                                   adc_sampleclk,
    input  logic                                   reset,
    input  logic                                   arm,
    input  logic                                   active,
    input  sad_cfg_pkg::sample_t                   adc_data,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [sad_regs_pkg::SAD_ADDR_BITS-1:0] paddr,
    input  logic [sad_regs_pkg::SAD_DATA_BITS-1:0] pwdata,
    output logic [sad_regs_pkg::SAD_DATA_BITS-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic                                   trigger
);
    import sad_cfg_pkg::*;

    ref_array_t ref_samples;
    sum_t       threshold;
    sample_t    max_dev;
    lane_vec_t  hits;
    lane_vec_t  lane_start;
    logic       lanes_clear;
    logic       running;

    sad_apb_regs u_regs (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .trigger       (trigger),
        .running       (running),
        .ref_samples   (ref_samples),
        .threshold     (threshold),
        .max_dev       (max_dev)
    );

    // one lane per window phase
    for (genvar i = 0; i < SAD_REF_SAMPLES; i++) begin : gen_lane
        sad_lane u_lane (
            .adc_sampleclk (adc_sampleclk),
            .reset         (reset),
            .lanes_clear   (lanes_clear),
            .start         (lane_start[i]),
            .adc_data      (adc_data),
            .ref_samples   (ref_samples),
            .threshold     (threshold),
            .max_dev       (max_dev),
            .hit           (hits[i])
        );
    end

    sad_sequencer u_seq (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .arm           (arm),
        .active        (active),
        .hits          (hits),
        .lane_start    (lane_start),
        .lanes_clear   (lanes_clear),
        .running       (running),
        .trigger       (trigger)
    );

endmodule

// File: tb_sad_top.sv
`timescale 1ns/1ps

module tb_sad_top;
    import sad_cfg_pkg::*;
    import sad_regs_pkg::*;

    logic                     adc_sampleclk;
    logic                     reset;
    logic                     arm;
    logic                     active;
    sample_t                  adc_data;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [SAD_ADDR_BITS-1:0] paddr;
    logic [SAD_DATA_BITS-1:0] pwdata;
    logic [SAD_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     trigger;

    logic [15:0] lfsr;
    int          cyc = 0;           // index of the current rising edge
    int          exp_edge = -100;   // edge where trigger should rise, negative if none
    int          trig_seen = 0;
    int          seq_errors = 0;
    int          mon_errors = 0;
    int          prop_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    sum_t        cfg_thr;           // copies of what was programmed
    sample_t     cfg_dev;
    sample_t     ref_vals [SAD_REF_SAMPLES];
    sample_t     pattern [SAD_REF_SAMPLES];
    sample_t     window_q [$];

    sad_top u_dut (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .arm           (arm),
        .active        (active),
        .adc_data      (adc_data),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .trigger       (trigger)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #4 adc_sampleclk = ~adc_sampleclk;
    end

    // trigger seen high at edge n means it rose at edge n-1
    always @(posedge adc_sampleclk) begin
        cyc <= cyc + 1;
        if (!reset) begin
            if (trigger) begin
                trig_seen <= trig_seen + 1;
            end
            assert (trigger == (cyc - 1 == exp_edge)) else begin
                $display("[ERROR] %0t trigger got %b expected %b", $time, trigger,
                         (cyc - 1 == exp_edge));
                mon_errors <= mon_errors + 1;
            end
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset) trigger |=> !trigger)
    else begin
        $display("%0t trigger stayed high for more than one cycle", $time);
        prop_errors++;
    end

    // no wait states, every access phase completes at once
    assert property (@(posedge adc_sampleclk) disable iff (reset) (psel && penable) |-> pready)
    else begin
        $display("[ERROR] %0t pready got %b expected 1", $time, $sampled(pready));
        prop_errors++;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            val  = {val[14:0], b};
        end
        return val;
    endfunction

    function automatic sample_t noise_sample();
        logic [15:0] r;
        r = rand_bits(10);
        return {2'b11, r[9:0]};  // far above any reference value
    endfunction

    function automatic int total_errors();
        return seq_errors + mon_errors + prop_errors;
    endfunction

    // sad of the model window against the reference, with the max_dev rule
    function automatic logic window_match();
        int      sum;
        logic    spoiled;
        sample_t d;
        sum     = 0;
        spoiled = 1'b0;
        for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
            d = (window_q[i] > ref_vals[i]) ? window_q[i] - ref_vals[i]
                                            : ref_vals[i] - window_q[i];
            sum += int'(d);
            if (cfg_dev != '0 && d > cfg_dev) begin
                spoiled = 1'b1;
            end
        end
        return (sum <= int'(cfg_thr)) && !spoiled;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            seq_errors++;
        end
    endtask

    task automatic write_reg(input logic [SAD_ADDR_BITS-1:0] addr,
                             input logic [SAD_DATA_BITS-1:0] data, output logic err);
        @(posedge adc_sampleclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge adc_sampleclk);
        penable <= 1'b1;
        @(negedge adc_sampleclk);
        err = pslverr;
        @(posedge adc_sampleclk);  // write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [SAD_ADDR_BITS-1:0] addr,
                            output logic [SAD_DATA_BITS-1:0] data, output logic err);
        @(posedge adc_sampleclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge adc_sampleclk);
        penable <= 1'b1;
        @(negedge adc_sampleclk);
        data = prdata;
        err  = pslverr;
        @(posedge adc_sampleclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input logic [SAD_ADDR_BITS-1:0] addr,
                            input logic [SAD_DATA_BITS-1:0] data);
        logic err;
        write_reg(addr, data, err);
        check_val($sformatf("pslverr[%h]", addr), 32'(err), 32'd0);
    endtask

    task automatic expect_read(input logic [SAD_ADDR_BITS-1:0] addr,
                               input logic [SAD_DATA_BITS-1:0] exp_data, input logic exp_err);
        logic [SAD_DATA_BITS-1:0] data;
        logic                     err;
        read_reg(addr, data, err);
        check_val($sformatf("prdata[%h]", addr), data, exp_data);
        check_val($sformatf("pslverr[%h]", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic set_config(input sum_t thr, input sample_t dev);
        write_ok(SAD_THRESHOLD_ADDR, 32'(thr));
        write_ok(SAD_MAX_DEV_ADDR, 32'(dev));
        cfg_thr = thr;
        cfg_dev = dev;
    endtask

    task automatic load_reference();
        logic [15:0] r;
        for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
            r           = rand_bits(10);
            ref_vals[i] = {2'b00, r[9:0]};
            write_ok(SAD_REF_BASE + 8'(4 * i), 32'(ref_vals[i]));
        end
    endtask

    // noise, then the pattern, then noise until the trigger or a timeout
    task automatic send_run(input int noise_len, input logic armed, output logic fired);
        int      start_seen;
        sample_t s;
        start_seen = trig_seen;
        exp_edge   = -100;
        window_q.delete();
        @(posedge adc_sampleclk);
        arm      <= armed;
        adc_data <= noise_sample();  // not taken, fsm enters running next edge
        for (int n = 0; n < noise_len + SAD_REF_SAMPLES + 16; n++) begin
            @(posedge adc_sampleclk);
            if (trig_seen != start_seen) begin
                break;
            end
            if (n >= noise_len && n < noise_len + SAD_REF_SAMPLES) begin
                s = pattern[n - noise_len];
            end else begin
                s = noise_sample();
            end
            adc_data <= s;
            if (armed) begin
                window_q.push_back(s);
                if (window_q.size() > SAD_REF_SAMPLES) begin
                    void'(window_q.pop_front());
                end
                // taken at cyc+1, trigger three edges later
                if (exp_edge < 0 && window_q.size() == SAD_REF_SAMPLES && window_match()) begin
                    exp_edge = cyc + 4;
                end
            end
        end
        if (exp_edge >= 0 && trig_seen == start_seen) begin
            $display("%0t timeout, no trigger arrived after the matching window", $time);
            seq_errors++;
        end
        @(posedge adc_sampleclk);
        arm      <= 1'b0;
        adc_data <= noise_sample();
        repeat (3) begin
            @(posedge adc_sampleclk);
            adc_data <= noise_sample();
        end
        fired = (trig_seen != start_seen);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, total_errors() - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int          errs_before;
        logic        fired;
        logic [15:0] r;
        lfsr     = 16'd10088;
        reset    = 1'b1;
        arm      = 1'b0;
        active   = 1'b0;
        adc_data = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        cfg_thr  = '0;
        cfg_dev  = '0;
        repeat (8) @(posedge adc_sampleclk);
        reset  <= 1'b0;
        active <= 1'b1;

        errs_before = total_errors();
        check_val("trigger", 32'(trigger), 32'd0);
        for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
            expect_read(SAD_REF_BASE + 8'(4 * i), 32'd0, 1'b0);
        end
        expect_read(SAD_THRESHOLD_ADDR, 32'd0, 1'b0);
        expect_read(SAD_MAX_DEV_ADDR, 32'd0, 1'b0);
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        load_reference();
        for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
            expect_read(SAD_REF_BASE + 8'(4 * i), 32'(ref_vals[i]), 1'b0);
        end
        write_ok(SAD_THRESHOLD_ADDR, 32'h1234_ABCD);  // upper bits dropped
        expect_read(SAD_THRESHOLD_ADDR, 32'h0000_ABCD, 1'b0);
        write_ok(SAD_MAX_DEV_ADDR, 32'hFFFF_F5A5);
        expect_read(SAD_MAX_DEV_ADDR, 32'h0000_05A5, 1'b0);
        expect_read(8'h20, 32'd0, 1'b1);
        expect_read(8'h81, 32'd0, 1'b1);
        expect_read(8'h8C, 32'd0, 1'b1);
        report_test("1 registers", errs_before);

        errs_before = total_errors();
        set_config(16'd0, 12'd0);
        load_reference();
        pattern = ref_vals;
        r = rand_bits(4);
        send_run(int'(r[3:0]), 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd1);
        report_test("2 exact match", errs_before);

        errs_before = total_errors();
        for (int i = 0; i < SAD_REF_SAMPLES; i++) begin
            pattern[i] = ref_vals[i] + sample_t'(i + 1);  // deviations sum to 36
        end
        set_config(16'd35, 12'd0);
        r = rand_bits(4);
        send_run(int'(r[3:0]), 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd0);
        set_config(16'd36, 12'd0);
        r = rand_bits(4);
        send_run(int'(r[3:0]), 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd1);
        report_test("3 threshold", errs_before);

        errs_before = total_errors();
        pattern    = ref_vals;
        pattern[3] = ref_vals[3] + 12'd300;
        set_config(16'd1000, 12'd100);
        send_run(0, 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd0);
        set_config(16'd1000, 12'd400);
        send_run(3, 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd1);
        set_config(16'd1000, 12'd0);
        send_run(0, 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd1);
        report_test("4 max_dev", errs_before);

        errs_before = total_errors();
        write_ok(SAD_STATUS_ADDR, 32'hFFFF_FFFF);
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        set_config(16'd0, 12'd0);
        pattern = ref_vals;
        send_run(5, 1'b1, fired);
        check_val("trigger_fired", 32'(fired), 32'd1);
        expect_read(SAD_STATUS_ADDR, 32'd1 << SAD_STATUS_TRIGGERED, 1'b0);
        write_ok(SAD_STATUS_ADDR, 32'd0);
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        @(posedge adc_sampleclk);
        arm <= 1'b1;  // constant noise on adc_data keeps the run going
        expect_read(SAD_STATUS_ADDR, 32'd1 << SAD_STATUS_RUNNING, 1'b0);
        arm <= 1'b0;
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        arm    <= 1'b1;
        active <= 1'b0;  // capture off holds the fsm in idle
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        active <= 1'b1;
        arm    <= 1'b0;
        send_run(2, 1'b0, fired);
        check_val("trigger_fired", 32'(fired), 32'd0);
        expect_read(SAD_STATUS_ADDR, 32'd0, 1'b0);
        report_test("5 status and arming", errs_before);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
sad_cfg_pkg.sv
sad_regs_pkg.sv
sad_apb_regs.sv
sad_lane.sv
sad_sequencer.sv
sad_top.sv
tb_sad_top.sv
